// File: rv_fetch_top.f
+incdir+src
src/rv_pkg.sv
src/stage_if.sv
src/fetch_queue.sv
src/inst_expander.sv
src/rv_fetch_top.sv
test/fetch_assert.sv
test/fetch_checker.sv
test/tb_rv_fetch.sv

// File: test/fetch_patterns.txt
// pc       raw      expanded illegal redirect_target
// Compressed lines hold only the halfword in raw, a target of 0 means fall through
00000000 00004515 00500513 0 00000000
00000002 0000157d fff50513 0 00000000
00000004 007302b3 007302b3 0 00000000
00000008 000085b2 00c005b3 0 00000000
0000000a 000095aa 00a585b3 0 00000000
0000000c 00004044 00442483 0 00000000
0000000e 0000c488 00a4a423 0 00000000
00000010 0000a001 0000a001 1 00000000
00000012 00a0006f 00a0006f 0 0000001c
00000016 00100093 00100093 0 00000000
0000001a 00004085 00100093 0 00000000
0000001c 00000013 00000013 0 00000000
00000020 00008082 00008082 1 00000000
00000022 0000040d 00340413 0 0000002c
00000024 deadbeef deadbeef 0 00000000
0000002c 00b50533 00b50533 0 00000000

// File: test/tb_rv_fetch.sv
module tb_rv_fetch;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_LINES  = 32;
    localparam int PAT_WORDS  = MAX_LINES * 5;  // Five columns per line
    localparam int MEM_HW     = 64;             // Halfwords in the memory model
    localparam int CLK_PERIOD = 10;
    localparam int RESET_CYC  = 10;

    // DUT ports
    logic               i_clock;
    logic               i_rst_n;
    logic               i_mem_rd_en;
    logic               i_mem_wr_en;
    logic               i_redirect;
    rv_pkg::inst_addr_t i_redirect_pc;
    rv_pkg::inst_t      i_inst_data;
    logic               i_dec_ready;
    rv_pkg::inst_addr_t o_inst_addr;
    logic               o_hazard;
    logic               o_valid;
    rv_pkg::inst_t      o_inst;
    logic               o_inst_compressed;
    logic               o_illegal;
    rv_pkg::inst_addr_t o_pc;

    logic [31:0]        pat [PAT_WORDS];
    logic [15:0]        hmem [MEM_HW];
    int                 num_lines;
    logic [31:0]        hw_idx;          // Halfword index of the fetch address
    logic               redirect_req;
    rv_pkg::inst_addr_t redirect_pc;
    logic               chk_done;
    int                 chk_errors;
    logic [31:0]        rng;             // Xorshift state

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic close_run(input bit timed_out);
        int assert_errors;
        assert_errors = UUT.u_stage_if.u_assert_if.fail_count
                      + UUT.u_fetch_queue.u_assert_q.fail_count;
        $display("Errors: checker %0d, assertions %0d, timeout %0d",
                 chk_errors, assert_errors, timed_out);
        if (chk_errors == 0 && assert_errors == 0 && !timed_out) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    rv_fetch_top UUT (.*);

    fetch_checker #(.MAX_LINES(MAX_LINES)) u_checker (
        .i_clock           (i_clock),
        .i_rst_n           (i_rst_n),
        .i_pat             (pat),
        .i_num_lines       (num_lines),
        .i_mem_rd_en       (i_mem_rd_en),
        .i_mem_wr_en       (i_mem_wr_en),
        .i_redirect        (i_redirect),
        .i_dec_ready       (i_dec_ready),
        .i_hazard          (o_hazard),
        .i_valid           (o_valid),
        .i_inst            (o_inst),
        .i_inst_compressed (o_inst_compressed),
        .i_illegal         (o_illegal),
        .i_pc              (o_pc),
        .o_redirect_req    (redirect_req),
        .o_redirect_pc     (redirect_pc),
        .o_done            (chk_done),
        .o_error_count     (chk_errors)
    );

    // ----------------------------------------------------------
    // Instruction memory, two halfwords at any even address
    // ----------------------------------------------------------

    always_comb begin
        hw_idx = o_inst_addr >> 1;
        i_inst_data[15:0]  = (hw_idx < MEM_HW) ? hmem[hw_idx] : 16'h0000;      // Unmapped reads 0
        i_inst_data[31:16] = (hw_idx + 1 < MEM_HW) ? hmem[hw_idx + 1] : 16'h0000;
    end

    initial begin
        i_clock = 1'b0;
        forever #(CLK_PERIOD / 2) i_clock = ~i_clock;
    end

    // Pattern load, then watchdog
    initial begin : load_and_watch
        int k;
        for (k = 0; k < MEM_HW; k++) begin
            hmem[k] = 16'h0000;
        end
        for (k = 0; k < PAT_WORDS; k++) begin
            pat[k] = 32'hffff_ffff;             // Lines past the end keep an odd PC
        end
        $readmemh("test/fetch_patterns.txt", pat);
        num_lines = 0;
        while (num_lines < MAX_LINES && pat[num_lines*5] !== 32'hffff_ffff) begin
            num_lines++;
        end
        for (k = 0; k < num_lines; k++) begin
            hmem[pat[k*5] >> 1] = pat[k*5 + 1][15:0];
            if (pat[k*5 + 1][1:0] == 2'b11) begin
                hmem[(pat[k*5] >> 1) + 1] = pat[k*5 + 1][31:16];  // Upper half of 32-bit word
            end
        end
        #((num_lines * 50 + RESET_CYC) * CLK_PERIOD);
        $display("Timeout: the checker did not reach the end of the pattern list");
        close_run(1'b1);
    end

    initial begin
        i_rst_n       = 1'b0;
        i_mem_rd_en   = 1'b0;
        i_mem_wr_en   = 1'b0;
        i_redirect    = 1'b0;
        i_redirect_pc = '0;
        i_dec_ready   = 1'b0;
        rng           = 32'hfda9dc61;
        repeat (RESET_CYC) @(posedge i_clock);
        i_rst_n <= 1'b1;
        wait (chk_done === 1'b1);
        @(posedge i_clock);
        close_run(1'b0);
    end

    // Random MEM activity and decode stalls, decode held off while redirecting
    always @(posedge i_clock) begin
        if (i_rst_n) begin
            rng = xorshift32(rng);
            i_mem_rd_en   <= (rng[1:0] == 2'b00);
            i_mem_wr_en   <= (rng[9:8] == 2'b00);
            i_redirect    <= redirect_req;
            i_redirect_pc <= redirect_req ? redirect_pc : '0;
            i_dec_ready   <= redirect_req ? 1'b0 : (rng[17:16] != 2'b00);
        end
    end

endmodule

// File: test/fetch_checker.sv
module fetch_checker #(
    parameter int MAX_LINES = 32
) (
    input  logic               i_clock,
    input  logic               i_rst_n,
    input  logic [31:0]        i_pat [MAX_LINES*5],  // pc, raw, inst, illegal, target
    input  int                 i_num_lines,
    input  logic               i_mem_rd_en,
    input  logic               i_mem_wr_en,
    input  logic               i_redirect,
    input  logic               i_dec_ready,
    input  logic               i_hazard,
    input  logic               i_valid,
    input  rv_pkg::inst_t      i_inst,
    input  logic               i_inst_compressed,
    input  logic               i_illegal,
    input  rv_pkg::inst_addr_t i_pc,
    output logic               o_redirect_req,       // Accepting a jump line now
    output rv_pkg::inst_addr_t o_redirect_pc,
    output logic               o_done,
    output int                 o_error_count
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int F_PC   = 0;
    localparam int F_RAW  = 1;
    localparam int F_INST = 2;
    localparam int F_ILL  = 3;
    localparam int F_TGT  = 4;

    int                 idx = 0;      // Expected pattern line
    int                 errors = 0;
    int                 next_idx;
    int                 k;
    logic               accept;       // Decode takes the output this edge
    logic               held = 1'b0;  // Output stalled at the last edge
    rv_pkg::inst_addr_t held_pc;
    rv_pkg::inst_t      held_inst;
    logic [1:0]         held_flags;   // Compressed, illegal

    assign accept = i_rst_n & i_valid & i_dec_ready & ~i_redirect & (idx < i_num_lines);
    assign o_redirect_pc  = (idx < i_num_lines) ? i_pat[idx*5 + F_TGT] : '0;
    assign o_redirect_req = accept & (o_redirect_pc != '0);
    assign o_done         = (i_num_lines > 0) && (idx >= i_num_lines);
    assign o_error_count  = errors;

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got %h, expected %h (line %0d)", name, got, exp, idx);
        end
    endtask

    // ----------------------------------------------------------
    // Per-edge comparison
    // ----------------------------------------------------------

    always @(posedge i_clock) begin
        if (!i_rst_n) begin
            idx  <= 0;
            held <= 1'b0;
            if (i_valid !== 1'b0) begin
                errors++;
                $display("o_valid is not low while reset is held");
            end
        end else begin
            check_val("o_hazard", 32'(i_hazard), 32'(i_mem_rd_en | i_mem_wr_en));
            if (held) begin                             // Stalled output must not move
                check_val("o_valid", 32'(i_valid), 32'd1);
                check_val("o_pc", i_pc, held_pc);
                check_val("o_inst", i_inst, held_inst);
                check_val("o_inst_compressed", 32'(i_inst_compressed), 32'(held_flags[1]));
                check_val("o_illegal", 32'(i_illegal), 32'(held_flags[0]));
            end
            held       <= i_valid & ~i_dec_ready & ~i_redirect;
            held_pc    <= i_pc;
            held_inst  <= i_inst;
            held_flags <= {i_inst_compressed, i_illegal};

            if (accept) begin
                check_val("o_pc", i_pc, i_pat[idx*5 + F_PC]);
                check_val("o_inst", i_inst, i_pat[idx*5 + F_INST]);
                check_val("o_inst_compressed", 32'(i_inst_compressed),
                          32'(i_pat[idx*5 + F_RAW][1:0] != 2'b11));  // Quadrant 3 is 32-bit
                check_val("o_illegal", 32'(i_illegal), 32'(i_pat[idx*5 + F_ILL][0]));
                if (o_redirect_pc != '0) begin
                    // Jump, continue at the line holding the target
                    next_idx = i_num_lines;
                    for (k = 0; k < i_num_lines; k++) begin
                        if (next_idx == i_num_lines && i_pat[k*5 + F_PC] == o_redirect_pc) begin
                            next_idx = k;
                        end
                    end
                    if (next_idx == i_num_lines) begin
                        errors++;
                        $display("Redirect target %h is missing from the pattern list",
                                 o_redirect_pc);
                    end
                    idx <= next_idx;
                end else begin
                    idx <= idx + 1;
                end
            end
        end
    end

endmodule

// File: test/fetch_assert.sv
module fetch_assert #(
    parameter bit CHECK_FLOW = 1'b1,  // Push and pop against the queue flags
    parameter bit CHECK_ADDR = 1'b1   // Halfword aligned fetch address
) (
    input logic        i_clock,
    input logic        i_rst_n,
    input logic        i_push,
    input logic        i_full,
    input logic        i_pop,
    input logic        i_empty,
    input logic [31:0] i_addr
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;   // Failed assertions in this instance

    // ----------------------------------------------------------
    // Queue flow
    // ----------------------------------------------------------

    if (CHECK_FLOW) begin : g_flow
        push_not_full: assert property (@(posedge i_clock) disable iff (!i_rst_n)
            !(i_push && i_full))
            else begin
                fail_count++;
                $error("push into a full fetch queue");
            end

        pop_not_empty: assert property (@(posedge i_clock) disable iff (!i_rst_n)
            !(i_pop && i_empty))
            else begin
                fail_count++;
                $error("pop from an empty fetch queue");
            end
    end

    // ----------------------------------------------------------
    // Fetch address
    // ----------------------------------------------------------

    if (CHECK_ADDR) begin : g_addr
        // Fetch only at halfword boundaries
        addr_aligned: assert property (@(posedge i_clock) disable iff (!i_rst_n)
            i_addr[0] == 1'b0)
            else begin
                fail_count++;
                $error("fetch address is not halfword aligned");
            end
    end

endmodule

// Fetch address check in the producer
bind stage_if fetch_assert #(.CHECK_FLOW(1'b0)) u_assert_if (
    .i_clock (i_clock), .i_rst_n (i_rst_n),
    .i_push  (1'b0),    .i_full  (1'b0),
    .i_pop   (1'b0),    .i_empty (1'b0),
    .i_addr  (o_inst_addr)
);

// Push and pop checks at the queue
bind fetch_queue fetch_assert #(.CHECK_ADDR(1'b0)) u_assert_q (
    .i_clock (i_clock), .i_rst_n (i_rst_n),
    .i_push  (i_push),  .i_full  (o_full),
    .i_pop   (i_pop),   .i_empty (o_empty),
    .i_addr  (32'd0)
);

// File: src/rv_fetch_top.sv
`include "rv_cfg.svh"

module rv_fetch_top (
    input  logic               i_clock,
    input  logic               i_rst_n,

    // Memory stage
    input  logic               i_mem_rd_en,
    input  logic               i_mem_wr_en,

    // Redirect
    input  logic               i_redirect,
    input  rv_pkg::inst_addr_t i_redirect_pc,

    // Instruction memory
    output rv_pkg::inst_addr_t o_inst_addr,
    input  rv_pkg::inst_t      i_inst_data,

    // Decode
    input  logic               i_dec_ready,
    output logic               o_hazard,
    output logic               o_valid,
    output rv_pkg::inst_t      o_inst,
    output logic               o_inst_compressed,
    output logic               o_illegal,
    output rv_pkg::inst_addr_t o_pc
);

    // ----------------------------------------------------------
    // Internal wiring
    // ----------------------------------------------------------

    logic                 q_full;
    logic                 q_empty;
    logic                 push;
    rv_pkg::fetch_entry_t push_entry;
    logic                 pop;
    rv_pkg::fetch_entry_t head;

    // Producer
    stage_if u_stage_if (
        .i_clock       (i_clock),
        .i_rst_n       (i_rst_n),
        .i_mem_rd_en   (i_mem_rd_en),
        .i_mem_wr_en   (i_mem_wr_en),
        .i_redirect    (i_redirect),
        .i_redirect_pc (i_redirect_pc),
        .o_inst_addr   (o_inst_addr),
        .i_inst_data   (i_inst_data),
        .i_q_full      (q_full),
        .o_push        (push),
        .o_push_entry  (push_entry),
        .o_hazard      (o_hazard)
    );

    // Buffer, flushed by the redirect pulse
    fetch_queue #(
        .T_ENTRY (rv_pkg::fetch_entry_t),
        .DEPTH   (`RV_FETCH_DEPTH)
    ) u_fetch_queue (
        .i_clock     (i_clock),
        .i_rst_n     (i_rst_n),
        .i_flush     (i_redirect),
        .i_push      (push),
        .i_push_data (push_entry),
        .i_pop       (pop),
        .o_head      (head),
        .o_empty     (q_empty),
        .o_full      (q_full)
    );

    // Consumer
    inst_expander u_inst_expander (
        .i_clock           (i_clock),
        .i_rst_n           (i_rst_n),
        .i_flush           (i_redirect),
        .i_head            (head),
        .i_empty           (q_empty),
        .o_pop             (pop),
        .i_dec_ready       (i_dec_ready),
        .o_valid           (o_valid),
        .o_inst            (o_inst),
        .o_inst_compressed (o_inst_compressed),
        .o_illegal         (o_illegal),
        .o_pc              (o_pc)
    );

endmodule

// File: src/inst_expander.sv
`include "rv_cfg.svh"

module inst_expander (
    input  logic                 i_clock,
    input  logic                 i_rst_n,
    input  logic                 i_flush,           // Redirect

    // Queue side
    input  rv_pkg::fetch_entry_t i_head,
    input  logic                 i_empty,
    output logic                 o_pop,

    // Decode side
    input  logic                 i_dec_ready,
    output logic                 o_valid,
    output rv_pkg::inst_t        o_inst,            // 32-bit form
    output logic                 o_inst_compressed, // Came from a halfword
    output logic                 o_illegal,         // Unsupported RVC
    output rv_pkg::inst_addr_t   o_pc
);

    logic [15:0]   c;            // Low half of the head word
    logic          is_c;         // Head is compressed
    logic [4:0]    rd_rs1;       // Bits 11:7
    logic [4:0]    rs2;          // Bits 6:2
    logic [4:0]    rs1_p;        // x8..x15 from bits 9:7
    logic [4:0]    rd_rs2_p;     // x8..x15 from bits 4:2
    logic [11:0]   imm_ci;       // Sign extended CI immediate
    logic [6:0]    off_cl;       // C.LW and C.SW byte offset
    rv_pkg::inst_t exp_inst;
    logic          exp_illegal;
    logic          valid_q;

    // ----------------------------------------------------------
    // Field extraction
    // ----------------------------------------------------------

    assign c    = i_head.raw[15:0];
    assign is_c = `RV_EXT_C && (c[1:0] != rv_pkg::RVC_FULL);

    assign rd_rs1   = c[11:7];
    assign rs2      = c[6:2];
    assign rs1_p    = {2'b01, c[9:7]};
    assign rd_rs2_p = {2'b01, c[4:2]};
    assign imm_ci   = {{6{c[12]}}, c[12], c[6:2]};
    assign off_cl   = {c[5], c[12:10], c[6], 2'b00};  // Word aligned

    // ----------------------------------------------------------
    // RVC expansion
    // ----------------------------------------------------------

    always_comb begin
        exp_inst    = i_head.raw;       // Full-length word passes through
        exp_illegal = 1'b0;
        if (is_c) begin
            // Unsupported encodings keep the raw halfword
            exp_inst    = {16'h0000, c};
            exp_illegal = 1'b1;
            case (c[1:0])
                rv_pkg::RVC_Q0: begin
                    if (c[15:13] == rv_pkg::RVC_F3_LW) begin
                        // lw rd', off(rs1')
                        exp_inst    = {5'b00000, off_cl, rs1_p, rv_pkg::F3_WORD,
                                       rd_rs2_p, rv_pkg::OPC_LOAD};
                        exp_illegal = 1'b0;
                    end else if (c[15:13] == rv_pkg::RVC_F3_SW) begin
                        // sw rs2', off(rs1')
                        exp_inst    = {5'b00000, off_cl[6:5], rd_rs2_p, rs1_p,
                                       rv_pkg::F3_WORD, off_cl[4:0], rv_pkg::OPC_STORE};
                        exp_illegal = 1'b0;
                    end
                end
                rv_pkg::RVC_Q1: begin
                    if (c[15:13] == rv_pkg::RVC_F3_ADDI) begin
                        // addi rd, rd, imm
                        exp_inst    = {imm_ci, rd_rs1, rv_pkg::F3_ADD, rd_rs1,
                                       rv_pkg::OPC_OP_IMM};
                        exp_illegal = 1'b0;
                    end else if (c[15:13] == rv_pkg::RVC_F3_LI) begin
                        // addi rd, x0, imm
                        exp_inst    = {imm_ci, 5'd0, rv_pkg::F3_ADD, rd_rs1,
                                       rv_pkg::OPC_OP_IMM};
                        exp_illegal = 1'b0;
                    end
                end
                rv_pkg::RVC_Q2: begin
                    // rs2 of zero is C.JR, C.JALR or C.EBREAK
                    if (c[15:13] == rv_pkg::RVC_F3_MV_ADD && rs2 != 5'd0) begin
                        if (c[12]) begin
                            // add rd, rd, rs2
                            exp_inst = {7'b0000000, rs2, rd_rs1, rv_pkg::F3_ADD,
                                        rd_rs1, rv_pkg::OPC_OP};
                        end else begin
                            // add rd, x0, rs2
                            exp_inst = {7'b0000000, rs2, 5'd0, rv_pkg::F3_ADD,
                                        rd_rs1, rv_pkg::OPC_OP};
                        end
                        exp_illegal = 1'b0;
                    end
                end
                default: ;                      // Not reached while is_c
            endcase
        end
    end

    // ----------------------------------------------------------
    // Output register
    // ----------------------------------------------------------

    // Pop when the register is free or being accepted
    assign o_pop   = ~i_empty & ~i_flush & (~valid_q | i_dec_ready);
    assign o_valid = valid_q;

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_q <= 1'b0;
        end else if (i_flush) begin
            valid_q <= 1'b0;                    // Old path dropped
        end else if (o_pop) begin
            valid_q <= 1'b1;
        end else if (i_dec_ready) begin
            valid_q <= 1'b0;                    // Accepted, nothing behind
        end
    end

    // Payload only moves on pop, so it holds under back-pressure
    always_ff @(posedge i_clock) begin
        if (o_pop) begin
            o_inst            <= exp_inst;
            o_inst_compressed <= is_c;
            o_illegal         <= exp_illegal;
            o_pc              <= i_head.pc;
        end
    end

endmodule

// File: src/fetch_queue.sv
module fetch_queue #(
    parameter type T_ENTRY = logic [31:0],  // Payload
    parameter int  DEPTH   = 4              // At least 2
) (
    input  logic   i_clock,
    input  logic   i_rst_n,
    input  logic   i_flush,      // Drop all entries
    input  logic   i_push,
    input  T_ENTRY i_push_data,
    input  logic   i_pop,
    output T_ENTRY o_head,       // Oldest entry
    output logic   o_empty,
    output logic   o_full
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    T_ENTRY           mem [DEPTH];  // Circular storage
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;        // Entries held
    logic             do_push;
    logic             do_pop;

    // Pointer increment with wrap, any depth
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return p + PTR_W'(1);
    endfunction

    // ----------------------------------------------------------
    // Flags and head
    // ----------------------------------------------------------

    assign o_empty = (count == '0);
    assign o_full  = (count == CNT_W'(DEPTH));
    assign o_head  = mem[rd_ptr];

    assign do_push = i_push & ~o_full;   // Overflow guard
    assign do_pop  = i_pop & ~o_empty;   // Underflow guard

    // Storage
    always_ff @(posedge i_clock) begin
        if (do_push) begin
            mem[wr_ptr] <= i_push_data;
        end
    end

    // ----------------------------------------------------------
    // Pointers and count
    // ----------------------------------------------------------

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (i_flush) begin
            wr_ptr <= '0;                // Redirect empties the queue
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;  // Both or neither
            endcase
        end
    end

endmodule

// File: src/stage_if.sv
`include "rv_cfg.svh"

module stage_if (
    // Clock and reset
    input  logic                 i_clock,
    input  logic                 i_rst_n,

    // Memory stage activity on the shared port
    input  logic                 i_mem_rd_en,   // Load in MEM
    input  logic                 i_mem_wr_en,   // Store in MEM

    // Redirect from execute
    input  logic                 i_redirect,    // One-cycle pulse
    input  rv_pkg::inst_addr_t   i_redirect_pc, // Target

    // Instruction memory
    output rv_pkg::inst_addr_t   o_inst_addr,   // Fetch address
    input  rv_pkg::inst_t        i_inst_data,   // Word at o_inst_addr

    // Queue side
    input  logic                 i_q_full,
    output logic                 o_push,
    output rv_pkg::fetch_entry_t o_push_entry,

    // Stall indication to decode
    output logic                 o_hazard
);

    rv_pkg::inst_addr_t pc_q;          // Current fetch PC
    rv_pkg::inst_addr_t pc_step;       // 2 or 4
    rv_pkg::inst_addr_t pc_next;
    logic               is_compressed; // Low bits not 2'b11
    logic               advance;       // Word taken this cycle

    // ----------------------------------------------------------
    // Hazard detection
    // ----------------------------------------------------------

    // MEM owns the port while it loads or stores
    assign o_hazard = i_mem_rd_en | i_mem_wr_en;

    // ----------------------------------------------------------
    // Fetch and push
    // ----------------------------------------------------------

    assign o_inst_addr = pc_q;

    // Redirect kills the word fetched on the old path
    assign advance = ~o_hazard & ~i_redirect & ~i_q_full;
    assign o_push  = advance;

    assign o_push_entry.pc  = pc_q;
    assign o_push_entry.raw = i_inst_data;

    // ----------------------------------------------------------
    // Next PC
    // ----------------------------------------------------------

    // Step by 2 only with the C extension built in
    assign is_compressed = `RV_EXT_C && (i_inst_data[1:0] != rv_pkg::RVC_FULL);
    assign pc_step       = is_compressed ? 32'd2 : 32'd4;

    always_comb begin
        if (i_redirect) begin
            pc_next = i_redirect_pc;        // Redirect wins over everything
        end else if (advance) begin
            pc_next = pc_q + pc_step;
        end else begin
            pc_next = pc_q;                 // Hazard or full queue
        end
    end

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc_q <= `RV_RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

endmodule

// File: src/rv_pkg.sv
package rv_pkg;

    // ----------------------------------------------------------
    // Fetch types
    // ----------------------------------------------------------

    typedef logic [31:0] inst_t;       // Instruction word
    typedef logic [31:0] inst_addr_t;  // Instruction address

    // One fetched word with its PC, PC in the upper half
    typedef struct packed {
        inst_addr_t pc;
        inst_t      raw;
    } fetch_entry_t;

    // ----------------------------------------------------------
    // RVC encodings
    // ----------------------------------------------------------

    // Quadrant, bits 1:0 of the halfword
    localparam logic [1:0] RVC_Q0   = 2'b00;
    localparam logic [1:0] RVC_Q1   = 2'b01;
    localparam logic [1:0] RVC_Q2   = 2'b10;
    localparam logic [1:0] RVC_FULL = 2'b11;  // 32-bit instruction

    // funct3, bits 15:13 of the halfword
    localparam logic [2:0] RVC_F3_ADDI   = 3'b000;  // Quadrant 1
    localparam logic [2:0] RVC_F3_LI     = 3'b010;  // Quadrant 1
    localparam logic [2:0] RVC_F3_LW     = 3'b010;  // Quadrant 0
    localparam logic [2:0] RVC_F3_SW     = 3'b110;  // Quadrant 0
    localparam logic [2:0] RVC_F3_MV_ADD = 3'b100;  // Quadrant 2, bit 12 picks ADD

    // Base ISA fields used by the expansions
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [2:0] F3_ADD     = 3'b000;  // ADD and ADDI
    localparam logic [2:0] F3_WORD    = 3'b010;  // LW and SW

endpackage

// File: src/rv_cfg.svh
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// ----------------------------------------------------------
// Fetch subsystem build options
// ----------------------------------------------------------

// C extension enable
// 1'b1 expands compressed words, 1'b0 passes every word through
`define RV_EXT_C 1'b1

// Entries held between fetch and expansion
`define RV_FETCH_DEPTH 4

// PC loaded by reset
`define RV_RESET_PC 32'h0000_0000

`endif
